/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        WWD = 6'd28,
        HLT = 6'd29
    } func_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LHI
    } alu_op_t;

    typedef enum logic {
        RUN,
        HALTED
    } core_state_t;

    ////////////////////
    // Instruction fields
    localparam int OPCODE_HI = 15;
    localparam int OPCODE_LO = 12;
    localparam int RS_HI     = 11;
    localparam int RS_LO     = 10;
    localparam int RT_HI     = 9;
    localparam int RT_LO     = 8;
    localparam int RD_HI     = 7;
    localparam int RD_LO     = 6;
    localparam int FUNC_HI   = 5;
    localparam int FUNC_LO   = 0;
    localparam int IMM_HI    = 7;
    localparam int IMM_LO    = 0;

    // ORI $0, $0, 0
    localparam word_t NOP_INST = {ORI, 2'd0, 2'd0, 8'h00};

endpackage

`default_nettype wire

/* fetch_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fetch_if import cpu_pkg::*; ();

    logic  valid;
    logic  ready;
    word_t inst;
    word_t pc;

    modport sender (
        output valid,
        output inst,
        output pc,
        input  ready
    );

    modport receiver (
        input  valid,
        input  inst,
        input  pc,
        output ready
    );

endinterface

`default_nettype wire

/* inst_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_fetch import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    output logic     read_m1,
    output word_t    address1,
    input  word_t    data1,
    fetch_if.sender  out_q
);

    logic       fetch_en;
    word_t      pc;
    logic       in_flight;
    word_t      flight_pc;

    // Skid entries, oldest in slot 0
    logic [1:0] skid_count;
    word_t      skid_inst [2];
    word_t      skid_pc [2];

    logic       pop;
    logic       store;
    logic       wr_slot;

    // Never more than two words outstanding or held
    assign read_m1  = fetch_en && ((skid_count + 2'(in_flight)) < 2'd2);
    assign address1 = pc;

    // Empty skid passes the returning word straight through
    assign out_q.valid = (skid_count != 2'd0) || in_flight;
    assign out_q.inst  = (skid_count != 2'd0) ? skid_inst[0] : data1;
    assign out_q.pc    = (skid_count != 2'd0) ? skid_pc[0] : flight_pc;

    assign pop     = out_q.valid && out_q.ready;
    assign store   = in_flight && !(pop && skid_count == 2'd0);
    assign wr_slot = (skid_count == 2'd1) && !pop;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            fetch_en   <= 1'b0;
            pc         <= '0;
            in_flight  <= 1'b0;
            skid_count <= 2'd0;
        end else begin
            fetch_en   <= 1'b1;
            in_flight  <= read_m1;
            skid_count <= skid_count + 2'(in_flight) - 2'(pop);
            if (read_m1) begin
                pc <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_m1) begin
            flight_pc <= pc;
        end
        if (pop) begin
            skid_inst[0] <= skid_inst[1];
            skid_pc[0]   <= skid_pc[1];
        end
        // Later write wins over the shift above
        if (store) begin
            skid_inst[wr_slot] <= data1;
            skid_pc[wr_slot]   <= flight_pc;
        end
    end

    // A word never returns into a full skid
    a_skid_no_overflow: assert property (@(posedge clk) disable iff (reset_n)
        skid_count == 2'd2 |-> !in_flight);

endmodule

`default_nettype wire

/* inst_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_queue import cpu_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset_n,
    fetch_if.receiver in_q,
    fetch_if.sender   out_q
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(QUEUE_DEPTH);

    word_t            mem_inst [QUEUE_DEPTH];
    word_t            mem_pc [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign in_q.ready  = (count != FULL_COUNT);
    assign out_q.valid = (count != '0);
    assign out_q.inst  = mem_inst[rd_ptr];
    assign out_q.pc    = mem_pc[rd_ptr];

    assign wr_en = in_q.valid && in_q.ready;
    assign rd_en = out_q.valid && out_q.ready;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(wr_en) - (PTR_W + 1)'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_inst[wr_ptr] <= in_q.inst;
            mem_pc[wr_ptr]   <= in_q.pc;
        end
    end

    // Full queue with no read stays full, so nothing was written
    a_no_write_full: assert property (@(posedge clk) disable iff (reset_n)
        count == FULL_COUNT && !rd_en |=> count == FULL_COUNT);

    a_count_bound: assert property (@(posedge clk) disable iff (reset_n)
        count <= FULL_COUNT);

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t read1,
    input  reg_idx_t read2,
    input  reg_idx_t dest,
    input  word_t    write_data,
    input  logic     reg_write,
    output word_t    read_out1,
    output word_t    read_out2
);

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write) begin
            regs[dest] <= write_data;
        end
    end

    // Same-cycle writes reach the reader only through core forwarding
    assign read_out1 = regs[read1];
    assign read_out2 = regs[read2];

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            // Low byte of b moves up, low byte cleared
            ALU_LHI: begin
                result = {b[7:0], 8'h00};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    fetch_if.receiver in_q,
    output word_t     output_port,
    output logic      output_valid,
    input  logic      output_ready,
    output word_t     num_inst,
    output logic      is_halted
);

    core_state_t state;

    // Decode of the queue head
    opcode_t    opcode;
    func_t      func;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [7:0] imm;
    alu_op_t    dec_op;
    word_t      dec_b;
    reg_idx_t   dec_dest;
    logic       dec_write;
    logic       dec_wwd;
    logic       dec_hlt;

    word_t      rf_a;
    word_t      rf_b;
    word_t      opnd_a;
    word_t      opnd_b;
    word_t      alu_result;

    // Execute register
    logic       ex_valid;
    word_t      ex_result;
    word_t      ex_out;
    reg_idx_t   ex_dest;
    logic       ex_write;
    logic       ex_wwd;
    logic       ex_hlt;

    logic       hold;
    logic       retire;
    logic       accept;
    logic       rf_write;

    ////////////////////
    // Decode

    assign opcode = opcode_t'(in_q.inst[OPCODE_HI:OPCODE_LO]);
    assign func   = func_t'(in_q.inst[FUNC_HI:FUNC_LO]);
    assign rs     = in_q.inst[RS_HI:RS_LO];
    assign rt     = in_q.inst[RT_HI:RT_LO];
    assign rd     = in_q.inst[RD_HI:RD_LO];
    assign imm    = in_q.inst[IMM_HI:IMM_LO];

    always_comb begin
        dec_op    = ALU_ADD;
        dec_b     = opnd_b;
        dec_dest  = rt;
        dec_write = 1'b0;
        dec_wwd   = 1'b0;
        dec_hlt   = 1'b0;
        case (opcode)
            RTYPE: begin
                dec_dest = rd;
                case (func)
                    ADD: begin
                        dec_op    = ALU_ADD;
                        dec_write = 1'b1;
                    end
                    SUB: begin
                        dec_op    = ALU_SUB;
                        dec_write = 1'b1;
                    end
                    AND: begin
                        dec_op    = ALU_AND;
                        dec_write = 1'b1;
                    end
                    ORR: begin
                        dec_op    = ALU_OR;
                        dec_write = 1'b1;
                    end
                    WWD: dec_wwd = 1'b1;
                    HLT: dec_hlt = 1'b1;
                    default: dec_write = 1'b0;
                endcase
            end
            ADI: begin
                dec_b     = {{8{imm[7]}}, imm};
                dec_write = 1'b1;
            end
            ORI: begin
                dec_op    = ALU_OR;
                dec_b     = {8'h00, imm};
                dec_write = 1'b1;
            end
            LHI: begin
                dec_op    = ALU_LHI;
                dec_b     = {8'h00, imm};
                dec_write = 1'b1;
            end
            default: dec_write = 1'b0;
        endcase
    end

    ////////////////////
    // Operands and ALU

    // Result in the execute register is not yet in the register file
    assign opnd_a = (ex_valid && ex_write && ex_dest == rs) ? ex_result : rf_a;
    assign opnd_b = (ex_valid && ex_write && ex_dest == rt) ? ex_result : rf_b;

    register_file u_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .read1      (rs),
        .read2      (rt),
        .dest       (ex_dest),
        .write_data (ex_result),
        .reg_write  (rf_write),
        .read_out1  (rf_a),
        .read_out2  (rf_b)
    );

    alu u_alu (
        .a      (opnd_a),
        .b      (dec_b),
        .op     (dec_op),
        .result (alu_result)
    );

    ////////////////////
    // Execute, retire and halt

    assign hold     = ex_valid && ex_wwd && !output_ready;
    assign retire   = ex_valid && !hold;
    assign rf_write = retire && ex_write;

    // No accept behind a pending HLT
    assign in_q.ready = (state == RUN) && !hold && !(ex_valid && ex_hlt);
    assign accept     = in_q.valid && in_q.ready;

    assign output_valid = ex_valid && ex_wwd;
    assign output_port  = ex_out;
    assign is_halted    = (state == HALTED);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= RUN;
            ex_valid <= 1'b0;
            num_inst <= '0;
        end else begin
            if (!hold) begin
                ex_valid <= accept;
            end
            if (retire) begin
                num_inst <= num_inst + 16'd1;
            end
            if (retire && ex_hlt) begin
                state <= HALTED;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_result <= alu_result;
            ex_out    <= opnd_a;
            ex_dest   <= dec_dest;
            ex_write  <= dec_write;
            ex_wwd    <= dec_wwd;
            ex_hlt    <= dec_hlt;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (reset_n)
        output_valid && !output_ready |=> output_valid && $stable(output_port));

    // Once halted nothing enters execute and nothing retires
    a_halt_no_accept: assert property (@(posedge clk) disable iff (reset_n)
        state == HALTED |=> !ex_valid && $stable(num_inst));

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  clk,
    input  logic  reset_n,

    // Instruction memory
    output logic  read_m1,
    output word_t address1,
    input  word_t data1,

    // WWD output
    output word_t output_port,
    output logic  output_valid,
    input  logic  output_ready,

    output word_t num_inst,
    output logic  is_halted
);

    fetch_if fetch_to_queue ();
    fetch_if queue_to_core ();

    inst_fetch u_fetch (
        .clk      (clk),
        .reset_n  (reset_n),
        .read_m1  (read_m1),
        .address1 (address1),
        .data1    (data1),
        .out_q    (fetch_to_queue.sender)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk     (clk),
        .reset_n (reset_n),
        .in_q    (fetch_to_queue.receiver),
        .out_q   (queue_to_core.sender)
    );

    exec_core u_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_q         (queue_to_core.receiver),
        .output_port  (output_port),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

endmodule

`default_nettype wire

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int PROG_MAX   = 160;
    localparam int RAND_COUNT = 60;
    localparam int MAX_CYCLES = 5000;

    logic  clk = 1'b0;
    logic  reset_n;
    logic  read_m1;
    word_t address1;
    word_t data1;
    word_t output_port;
    logic  output_valid;
    logic  output_ready;
    word_t num_inst;
    logic  is_halted;

    word_t prog [PROG_MAX];
    int    prog_len;
    word_t exp_values [$];
    int    exp_count;
    word_t lfsr_state;

    // Memory model state
    logic  mem_pending;
    word_t mem_addr;
    word_t read_addr_exp;
    int    stall_left;

    cpu #(
        .QUEUE_DEPTH (4)
    ) i_cpu (
        .clk          (clk),
        .reset_n      (reset_n),
        .read_m1      (read_m1),
        .address1     (address1),
        .data1        (data1),
        .output_port  (output_port),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    always #20 clk = ~clk;

    ////////////////////
    // Random source

    // Taps 16, 14, 13, 11
    function automatic word_t lfsr_step(input word_t s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    ////////////////////
    // Program

    function automatic word_t enc_r(input func_t f, input reg_idx_t rs, input reg_idx_t rt,
                                    input reg_idx_t rd);
        return {RTYPE, rs, rt, rd, f};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                                    input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_inst(input word_t inst);
        prog[prog_len] = inst;
        prog_len++;
    endtask

    task automatic build_program();
        word_t    sel;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        prog_len = 0;
        // Immediates only ahead of the first WWD
        add_inst(enc_i(LHI, 2'd0, 2'd1, 8'h12));
        add_inst(enc_i(ORI, 2'd1, 2'd1, 8'h34));
        add_inst(enc_r(WWD, 2'd1, 2'd0, 2'd0));
        // Wraparound and sign extension
        add_inst(enc_i(LHI, 2'd0, 2'd2, 8'hff));
        add_inst(enc_i(ORI, 2'd2, 2'd2, 8'hf0));
        add_inst(enc_i(ADI, 2'd2, 2'd2, 8'h20));
        add_inst(enc_r(WWD, 2'd2, 2'd0, 2'd0));
        add_inst(enc_i(ADI, 2'd0, 2'd3, 8'h80));
        add_inst(enc_r(ADD, 2'd3, 2'd3, 2'd3));
        add_inst(enc_r(SUB, 2'd0, 2'd1, 2'd0));
        add_inst(enc_r(WWD, 2'd3, 2'd0, 2'd0));
        add_inst(enc_r(WWD, 2'd0, 2'd0, 2'd0));
        for (int n = 0; n < RAND_COUNT; n++) begin
            sel = rand_bits(3);
            rs  = reg_idx_t'(rand_bits(2));
            rt  = reg_idx_t'(rand_bits(2));
            rd  = reg_idx_t'(rand_bits(2));
            case (sel)
                16'd0: add_inst(enc_r(ADD, rs, rt, rd));
                16'd1: add_inst(enc_r(SUB, rs, rt, rd));
                16'd2: add_inst(enc_r(AND, rs, rt, rd));
                16'd3: add_inst(enc_r(ORR, rs, rt, rd));
                16'd5: add_inst(enc_i(ORI, rs, rt, rand_bits(8)));
                16'd6: add_inst(enc_i(LHI, rs, rt, rand_bits(8)));
                default: add_inst(enc_i(ADI, rs, rt, rand_bits(8)));
            endcase
            if (rand_bits(2) == 16'd0) begin
                add_inst(enc_r(WWD, reg_idx_t'(rand_bits(2)), 2'd0, 2'd0));
            end
        end
        for (int r = 0; r < 4; r++) begin
            add_inst(enc_r(WWD, reg_idx_t'(r), 2'd0, 2'd0));
        end
        add_inst(enc_r(HLT, 2'd0, 2'd0, 2'd0));
    endtask

    function automatic word_t fetch_word(input word_t addr);
        if (int'(addr) < prog_len) begin
            return prog[addr];
        end
        return NOP_INST;
    endfunction

    ////////////////////
    // Reference model

    // Returns the retired instruction count including HLT
    function automatic int run_reference();
        word_t      regs [4];
        word_t      inst;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [7:0] imm;
        int         count;
        for (int r = 0; r < 4; r++) begin
            regs[r] = '0;
        end
        count = 0;
        for (int pc = 0; pc < prog_len; pc++) begin
            inst = prog[pc];
            rs   = inst[11:10];
            rt   = inst[9:8];
            rd   = inst[7:6];
            imm  = inst[7:0];
            count++;
            case (inst[15:12])
                4'd4: regs[rt] = regs[rs] + {{8{imm[7]}}, imm};
                4'd5: regs[rt] = regs[rs] | {8'h00, imm};
                4'd6: regs[rt] = {imm, 8'h00};
                4'd15: begin
                    case (inst[5:0])
                        6'd0: regs[rd] = regs[rs] + regs[rt];
                        6'd1: regs[rd] = regs[rs] - regs[rt];
                        6'd2: regs[rd] = regs[rs] & regs[rt];
                        6'd3: regs[rd] = regs[rs] | regs[rt];
                        6'd28: exp_values.push_back(regs[rs]);
                        6'd29: return count;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
        return count;
    endfunction

    ////////////////////
    // Checks

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s = %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s = %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    // Word arrives one cycle after its read
    always @(negedge clk) begin
        if (mem_pending) begin
            data1 = fetch_word(mem_addr);
        end
        // Reads walk the program one address at a time
        if (read_m1 === 1'b1) begin
            check_word("address1", address1, read_addr_exp);
            read_addr_exp = read_addr_exp + 16'd1;
        end
        mem_pending = read_m1;
        mem_addr    = address1;
    end

    // Random stretches of back-pressure
    always @(negedge clk) begin
        if (stall_left != 0) begin
            output_ready = 1'b0;
            stall_left   = stall_left - 1;
        end else if (rand_bits(2) == 16'd0) begin
            output_ready = 1'b0;
            stall_left   = int'(rand_bits(3));
        end else begin
            output_ready = 1'b1;
        end
    end

    initial begin
        int    idx;
        int    cycles;
        logic  prev_hold;
        word_t prev_port;
        reset_n       = 1'b1;
        data1         = '0;
        output_ready  = 1'b0;
        mem_pending   = 1'b0;
        mem_addr      = '0;
        read_addr_exp = '0;
        stall_left    = 0;
        lfsr_state    = 16'd47;
        build_program();
        exp_count = run_reference();

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b0;

        // State right after reset
        check_bit("read_m1", read_m1, 1'b0);
        check_bit("output_valid", output_valid, 1'b0);
        check_bit("is_halted", is_halted, 1'b0);
        check_word("num_inst", num_inst, 16'd0);

        idx       = 0;
        cycles    = 0;
        prev_hold = 1'b0;
        prev_port = '0;
        while (!is_halted) begin
            @(posedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                stop_on_error("Timeout: the core never halted");
            end
            if (prev_hold) begin
                check_bit("output_valid", output_valid, 1'b1);
                check_word("output_port", output_port, prev_port);
            end
            if (output_valid && output_ready) begin
                if (idx >= exp_values.size()) begin
                    stop_on_error("The core sent more WWD values than the program holds");
                end
                check_word("output_port", output_port, exp_values[idx]);
                idx++;
            end
            prev_hold = output_valid && !output_ready;
            prev_port = output_port;
        end

        if (idx != exp_values.size()) begin
            stop_on_error("The core halted before sending every WWD value");
        end
        check_word("num_inst", num_inst, word_t'(exp_count));

        // Halt is sticky and the output stays quiet
        repeat (20) begin
            @(posedge clk);
            check_bit("is_halted", is_halted, 1'b1);
            check_bit("output_valid", output_valid, 1'b0);
            check_word("num_inst", num_inst, word_t'(exp_count));
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
cpu_pkg.sv
fetch_if.sv
inst_fetch.sv
inst_queue.sv
register_file.sv
alu.sv
exec_core.sv
cpu.sv
tb_cpu.sv
